// ==== memPkg.sv ====
package memPkg;

    // who asked for the access
    typedef enum logic [1:0] {
        OpFetch = 2'd0,
        OpLoad  = 2'd1,
        OpStore = 2'd2
    } memOp_t;

    // bytes moved by one request, fetch always behaves as Len4
    typedef enum logic [1:0] {
        Len1 = 2'd0,
        Len2 = 2'd1,
        Len4 = 2'd2
    } memLen_t;

    // one request as seen by a port, 68 bits
    typedef struct packed {
        memOp_t      op;
        memLen_t     len;
        // byte address, upper bits beyond the RAM are ignored
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReq_t;

    // loads and fetches zero-extended, zero for stores
    typedef struct packed {
        logic [31:0] rdata;
    } memRsp_t;

endpackage

// ==== reqPort.sv ====
module reqPort (
    input  logic            clk,
    input  logic            rst,
    // master side, four-phase
    input  logic            req,
    input  memPkg::memReq_t reqData,
    output logic            ack,
    output memPkg::memRsp_t rsp,
    // arbiter side
    output logic            pending,
    output memPkg::memReq_t pendReq,
    input  logic            finish,
    input  memPkg::memRsp_t finRsp
);
    import memPkg::*;

    typedef enum logic [1:0] {
        PortIdle,
        PortPending,
        PortAck
    } portState_t;

    portState_t state;

    assign pending = (state == PortPending);
    assign ack     = (state == PortAck);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PortIdle;
        end else begin
            case (state)
                PortIdle:    if (req) state <= PortPending;
                PortPending: if (finish) state <= PortAck;
                // wait for the master to let go
                PortAck:     if (!req) state <= PortIdle;
                default:     state <= PortIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PortIdle && req) begin
            pendReq <= reqData;
        end
        if (state == PortPending && finish) begin
            rsp <= finRsp;
        end
    end

    // a completion must belong to a request this port handed out
    finishNeedsPending: assert property (@(posedge clk) disable iff (rst)
        finish |-> pending);

endmodule

// ==== memArbiter.sv ====
module memArbiter (
    input  logic            clk,
    input  logic            rst,
    // port side
    input  logic            fetchPending,
    input  logic            dataPending,
    input  memPkg::memReq_t fetchReq,
    input  memPkg::memReq_t dataReq,
    output logic            fetchFinish,
    output logic            dataFinish,
    output memPkg::memRsp_t finRsp,
    // sequencer side
    output logic            start,
    output memPkg::memReq_t job,
    input  logic            busy,
    input  logic            done,
    input  memPkg::memRsp_t result
);
    import memPkg::*;

    logic grantOk;
    // set when the job in flight came from the data port
    logic ownerData;

    // start is still in flight for one cycle before busy rises
    assign grantOk = !busy && !start && (fetchPending || dataPending);

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            ownerData <= 1'b0;
        end else begin
            start <= grantOk;
            if (grantOk) begin
                ownerData <= dataPending;
            end
        end
    end

    // data side wins a tie
    always_ff @(posedge clk) begin
        if (grantOk) begin
            job <= dataPending ? dataReq : fetchReq;
        end
    end

    assign fetchFinish = done && !ownerData;
    assign dataFinish  = done && ownerData;
    assign finRsp      = result;

    // a start lands on an idle sequencer, which then goes busy
    startWhenIdle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy ##1 busy);

endmodule

// ==== byteSequencer.sv ====
module byteSequencer #(
    parameter int AddrWidth = 12
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hold,
    // job interface
    input  logic                 start,
    input  memPkg::memReq_t      job,
    output logic                 busy,
    output logic                 done,
    output memPkg::memRsp_t      result,
    // RAM side
    output logic                 ramWe,
    output logic [AddrWidth-1:0] ramAddr,
    output logic [7:0]           ramWdata,
    input  logic [7:0]           ramRdata
);
    import memPkg::*;

    typedef enum logic [1:0] {
        SeqIdle,
        SeqWrite,
        SeqRead,
        SeqLast
    } seqState_t;

    seqState_t   state;
    memReq_t     cur;
    logic [1:0]  count;
    logic [1:0]  lastIdx;
    logic [31:0] asmReg;
    logic [31:0] merged;
    logic        issueRead;
    // a read byte is arriving on ramRdata this cycle
    logic        capValid;
    logic [1:0]  capIdx;

    // index of the final byte, N-1
    always_comb begin
        if (cur.op == OpFetch) begin
            lastIdx = 2'd3;
        end else begin
            case (cur.len)
                Len1:    lastIdx = 2'd0;
                Len2:    lastIdx = 2'd1;
                default: lastIdx = 2'd3;
            endcase
        end
    end

    assign issueRead = (state == SeqRead) && !hold;
    assign ramWe     = (state == SeqWrite) && !hold;
    assign ramAddr   = cur.addr[AddrWidth-1:0] + AddrWidth'(count);
    assign ramWdata  = cur.wdata[8*count +: 8];
    assign busy      = (state != SeqIdle);
    assign done      = !hold && ((state == SeqWrite && count == lastIdx) || state == SeqLast);

    // little-endian placement of the byte in flight
    always_comb begin
        merged = asmReg;
        if (capValid) begin
            merged[8*capIdx +: 8] = ramRdata;
        end
    end

    assign result.rdata = (state == SeqLast) ? merged : 32'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SeqIdle;
            count    <= 2'd0;
            capValid <= 1'b0;
        end else begin
            capValid <= issueRead;
            case (state)
                // job is taken even under hold, RAM traffic waits for it
                SeqIdle: begin
                    if (start) begin
                        count <= 2'd0;
                        state <= (job.op == OpStore) ? SeqWrite : SeqRead;
                    end
                end
                SeqWrite: begin
                    if (!hold) begin
                        if (count == lastIdx) state <= SeqIdle;
                        else count <= count + 2'd1;
                    end
                end
                SeqRead: begin
                    if (!hold) begin
                        if (count == lastIdx) state <= SeqLast;
                        else count <= count + 2'd1;
                    end
                end
                SeqLast: if (!hold) state <= SeqIdle;
                default: state <= SeqIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        capIdx <= count;
        if (state == SeqIdle && start) begin
            cur    <= job;
            asmReg <= 32'd0;
        end else if (capValid) begin
            // late bytes are kept even while held
            asmReg <= merged;
        end
    end

    // a stall freezes the job in flight
    holdFreezes: assert property (@(posedge clk) disable iff (rst)
        hold && busy |=> $stable(state) && $stable(count));

endmodule

// ==== byteRam.sv ====
module byteRam #(
    parameter int AddrWidth = 12
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [AddrWidth-1:0] addr,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);

    logic [7:0] mem [2**AddrWidth];

    // read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== memSubsys.sv ====
module memSubsys #(
    parameter int AddrWidth = 12
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            hold,
    // instruction fetch master
    input  logic            fetchReq,
    input  memPkg::memReq_t fetchReqData,
    output logic            fetchAck,
    output memPkg::memRsp_t fetchRsp,
    // load/store master
    input  logic            dataReq,
    input  memPkg::memReq_t dataReqData,
    output logic            dataAck,
    output memPkg::memRsp_t dataRsp
);
    import memPkg::*;

    logic                 fetchPending;
    logic                 dataPending;
    memReq_t              fetchPendReq;
    memReq_t              dataPendReq;
    logic                 fetchFinish;
    logic                 dataFinish;
    memRsp_t              finRsp;
    logic                 start;
    memReq_t              job;
    logic                 busy;
    logic                 done;
    memRsp_t              result;
    logic                 ramWe;
    logic [AddrWidth-1:0] ramAddr;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    reqPort fetchPort (
        .clk(clk), .rst(rst),
        .req(fetchReq), .reqData(fetchReqData), .ack(fetchAck), .rsp(fetchRsp),
        .pending(fetchPending), .pendReq(fetchPendReq),
        .finish(fetchFinish), .finRsp(finRsp)
    );

    reqPort dataPort (
        .clk(clk), .rst(rst),
        .req(dataReq), .reqData(dataReqData), .ack(dataAck), .rsp(dataRsp),
        .pending(dataPending), .pendReq(dataPendReq),
        .finish(dataFinish), .finRsp(finRsp)
    );

    memArbiter arbiter (
        .clk(clk), .rst(rst),
        .fetchPending(fetchPending), .dataPending(dataPending),
        .fetchReq(fetchPendReq), .dataReq(dataPendReq),
        .fetchFinish(fetchFinish), .dataFinish(dataFinish), .finRsp(finRsp),
        .start(start), .job(job), .busy(busy), .done(done), .result(result)
    );

    byteSequencer #(.AddrWidth(AddrWidth)) sequencer (
        .clk(clk), .rst(rst), .hold(hold),
        .start(start), .job(job), .busy(busy), .done(done), .result(result),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    byteRam #(.AddrWidth(AddrWidth)) ram (
        .clk(clk),
        .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );

endmodule

// ==== tbClock.sv ====
module tbClock #(
    parameter realtime Period = 8ns
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

endmodule

// ==== memSubsysTb.sv ====
module memSubsysTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memPkg::*;

    localparam int AddrWidth = 12;
    localparam int Timeout   = 200;

    logic    clk;
    logic    rst;
    logic    hold;
    logic    fetchReq;
    memReq_t fetchReqData;
    logic    fetchAck;
    memRsp_t fetchRsp;
    logic    dataReq;
    memReq_t dataReqData;
    logic    dataAck;
    memRsp_t dataRsp;

    int         seed = 32'hccc1_fd1e;
    int         errors = 0;
    int         checks = 0;
    int         cycle = 0;
    logic [7:0] refMem [2**AddrWidth];

    tbClock #(.Period(8ns)) clkGen (.clk(clk));

    memSubsys #(.AddrWidth(AddrWidth)) UUT (
        .clk(clk), .rst(rst), .hold(hold),
        .fetchReq(fetchReq), .fetchReqData(fetchReqData),
        .fetchAck(fetchAck), .fetchRsp(fetchRsp),
        .dataReq(dataReq), .dataReqData(dataReqData),
        .dataAck(dataAck), .dataRsp(dataRsp)
    );

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int lenBytes(input memLen_t len);
        case (len)
            Len1:    return 1;
            Len2:    return 2;
            default: return 4;
        endcase
    endfunction

    // reference model, little-endian with zero fill above the last byte
    function automatic void refWrite(input logic [31:0] addr, input memLen_t len,
                                     input logic [31:0] wdata);
        logic [AddrWidth-1:0] idx;
        for (int k = 0; k < lenBytes(len); k++) begin
            idx = addr[AddrWidth-1:0] + AddrWidth'(k);
            refMem[idx] = wdata[8*k +: 8];
        end
    endfunction

    function automatic logic [31:0] refRead(input logic [31:0] addr, input memLen_t len);
        logic [AddrWidth-1:0] idx;
        logic [31:0]          val;
        val = 32'd0;
        for (int k = 0; k < lenBytes(len); k++) begin
            idx = addr[AddrWidth-1:0] + AddrWidth'(k);
            val[8*k +: 8] = refMem[idx];
        end
        return val;
    endfunction

    function automatic memReq_t makeReq(input memOp_t op, input memLen_t len,
                                        input logic [31:0] addr, input logic [31:0] wdata);
        memReq_t r;
        r.op    = op;
        r.len   = len;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // upper address bits stay random, the RAM ignores them
    function automatic logic [31:0] randWordAddr();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    function automatic logic portAck(input bit useData);
        return useData ? dataAck : fetchAck;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // one full four-phase transfer on the fetch or data port
    task automatic masterReq(input bit useData, input memReq_t r, input int linger,
                             output logic [31:0] rdata, output int ackAt);
        int waited;
        rdata = 'x;
        ackAt = -1;
        @(posedge clk);
        if (useData) begin
            dataReq     <= 1'b1;
            dataReqData <= r;
        end else begin
            fetchReq     <= 1'b1;
            fetchReqData <= r;
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!portAck(useData) && waited < Timeout);
        if (!portAck(useData)) begin
            errors++;
            $display("timeout: %s port never raised ack", useData ? "data" : "fetch");
        end else begin
            ackAt = cycle;
            rdata = useData ? dataRsp.rdata : fetchRsp.rdata;
        end
        // master dawdles, ack has to stay up
        for (int i = 0; i < linger; i++) begin
            @(posedge clk);
            checks++;
            assert (portAck(useData)) else begin
                errors++;
                $display("%s ack fell while req was still high", useData ? "data" : "fetch");
            end
        end
        if (useData) dataReq <= 1'b0;
        else fetchReq <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (portAck(useData) && waited < Timeout);
        if (portAck(useData)) begin
            errors++;
            $display("timeout: %s ack stayed high after req fell", useData ? "data" : "fetch");
        end
    endtask

    task automatic storeWrite(input logic [31:0] addr, input memLen_t len,
                              input logic [31:0] wdata);
        logic [31:0] got;
        int          at;
        masterReq(1'b1, makeReq(OpStore, len, addr, wdata), 0, got, at);
        checkWord("dataRsp.rdata", got, 32'd0);
        refWrite(addr, len, wdata);
    endtask

    // useData low means an instruction fetch, always four bytes
    task automatic readCheck(input bit useData, input logic [31:0] addr, input memLen_t len,
                             input int linger);
        logic [31:0] got;
        int          at;
        masterReq(useData, makeReq(useData ? OpLoad : OpFetch, len, addr, 32'd0),
                  linger, got, at);
        checkWord(useData ? "dataRsp.rdata" : "fetchRsp.rdata", got,
                  refRead(addr, useData ? len : Len4));
    endtask

    task automatic wordStoreLoad();
        logic [31:0] addr;
        repeat (6) begin
            addr = randWordAddr();
            storeWrite(addr, Len4, $random(seed));
            readCheck(1'b1, addr, Len4, 0);
        end
    endtask

    task automatic byteLayout();
        logic [31:0] addr;
        addr = randWordAddr();
        storeWrite(addr, Len4, $random(seed));
        for (int off = 0; off < 4; off++) readCheck(1'b1, addr + off, Len1, 0);
        for (int off = 0; off < 3; off++) readCheck(1'b1, addr + off, Len2, 0);
    endtask

    task automatic partialStores();
        logic [31:0] addr;
        addr = randWordAddr();
        storeWrite(addr, Len4, $random(seed));
        storeWrite(addr + 1, Len1, $random(seed));
        storeWrite(addr + 2, Len2, $random(seed));
        readCheck(1'b1, addr, Len4, 0);
        // fetch ignores len, still four bytes
        readCheck(1'b0, addr, Len1, 0);
    endtask

    task automatic arbitration();
        logic [31:0] dAddr;
        logic [31:0] fAddr;
        logic [31:0] dGot;
        logic [31:0] fGot;
        int          dAt;
        int          fAt;
        dAddr = randWordAddr();
        fAddr = dAddr ^ 32'h0000_0800;
        storeWrite(dAddr, Len4, $random(seed));
        storeWrite(fAddr, Len4, $random(seed));
        fork
            masterReq(1'b1, makeReq(OpLoad, Len4, dAddr, 32'd0), 0, dGot, dAt);
            masterReq(1'b0, makeReq(OpFetch, Len4, fAddr, 32'd0), 0, fGot, fAt);
        join
        checks++;
        assert (dAt >= 0 && dAt < fAt) else begin
            errors++;
            $display("data ack did not come before fetch ack on a tie");
        end
        checkWord("dataRsp.rdata", dGot, refRead(dAddr, Len4));
        checkWord("fetchRsp.rdata", fGot, refRead(fAddr, Len4));
    endtask

    task automatic holdStall();
        logic [31:0] sAddr;
        logic [31:0] fAddr;
        sAddr = randWordAddr();
        fAddr = sAddr ^ 32'h0000_0400;
        storeWrite(fAddr, Len4, $random(seed));
        fork
            storeWrite(sAddr, Len4, $random(seed));
            readCheck(1'b0, fAddr, Len4, 0);
            begin
                // store is part way through its bytes here
                repeat (5) @(posedge clk);
                hold <= 1'b1;
                repeat (20) begin
                    @(posedge clk);
                    checks++;
                    assert (!fetchAck && !dataAck) else begin
                        errors++;
                        $display("ack rose while hold was high");
                    end
                end
                hold <= 1'b0;
            end
        join
        readCheck(1'b1, sAddr, Len4, 0);
    endtask

    task automatic slowMaster();
        logic [31:0] addr;
        addr = randWordAddr();
        storeWrite(addr, Len4, $random(seed));
        readCheck(1'b1, addr, Len4, 12);
        readCheck(1'b0, addr, Len4, 9);
    endtask

    initial begin
        rst          = 1'b1;
        hold         = 1'b0;
        fetchReq     = 1'b0;
        fetchReqData = '0;
        dataReq      = 1'b0;
        dataReqData  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wordStoreLoad();
        byteLayout();
        partialStores();
        arbitration();
        holdStall();
        slowMaster();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
memPkg.sv
reqPort.sv
memArbiter.sv
byteSequencer.sv
byteRam.sv
memSubsys.sv
tbClock.sv
memSubsysTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
    --top-module memSubsysTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
